/* source/uart_pkg.sv */
package uart_pkg;

  // one frame is start, eight data, parity and stop.
  localparam int unsigned FRAME_BITS = 11;
  localparam int unsigned DATA_BITS  = 8;

  // command sequencer states.
  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SEND_HI,
    SEQ_WAIT_HI,
    SEQ_SEND_LO,
    SEQ_WAIT_LO
  } seq_state_e;

  // receiver states.
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

  // parity bit that makes the number of ones in data plus parity odd.
  function automatic logic odd_parity(input logic [DATA_BITS-1:0] data);
    logic p;
    p = ~^data; // even count of ones gives a one.
    return p;
  endfunction

endpackage

/* source/baud_timer.sv */
`timescale 1ns/1ps

module baud_timer #(
  parameter int BIT_CYCLES = 16
) (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic bit_tick,
  output logic mid_tick
);

  localparam int CW = (BIT_CYCLES > 1) ? $clog2(BIT_CYCLES) : 1;

  localparam logic [CW-1:0] LAST = CW'(BIT_CYCLES - 1);
  localparam logic [CW-1:0] HALF = CW'(BIT_CYCLES / 2);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0; // every run starts a fresh bit period.
    end else if (cnt == LAST) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick = run && (cnt == LAST);
  assign mid_tick = run && (cnt == HALF); // sample point inside the bit.

endmodule

/* source/cmd_sequencer.sv */
`timescale 1ns/1ps

module cmd_sequencer (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  input  logic        tx_done,
  output logic        cmd_rdy,
  output logic [7:0]  tx_byte,
  output logic        tx_start
);

  uart_pkg::seq_state_e state;
  uart_pkg::seq_state_e state_nxt;

  logic [15:0] cmd_hold; // accepted command, held for both frames.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_pkg::SEQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      uart_pkg::SEQ_IDLE: begin
        if (cmd_vld) begin
          state_nxt = uart_pkg::SEQ_SEND_HI;
        end
      end
      uart_pkg::SEQ_SEND_HI: begin
        state_nxt = uart_pkg::SEQ_WAIT_HI; // one start strobe only.
      end
      uart_pkg::SEQ_WAIT_HI: begin
        if (tx_done) begin
          state_nxt = uart_pkg::SEQ_SEND_LO;
        end
      end
      uart_pkg::SEQ_SEND_LO: begin
        state_nxt = uart_pkg::SEQ_WAIT_LO;
      end
      uart_pkg::SEQ_WAIT_LO: begin
        if (tx_done) begin
          state_nxt = uart_pkg::SEQ_IDLE;
        end
      end
      default: begin
        state_nxt = uart_pkg::SEQ_IDLE;
      end
    endcase
  end

  // capture on acceptance.
  always_ff @(posedge clk) begin
    if (cmd_rdy && cmd_vld) begin
      cmd_hold <= cmd_in;
    end
  end

  assign cmd_rdy  = (state == uart_pkg::SEQ_IDLE);
  assign tx_start = (state == uart_pkg::SEQ_SEND_HI) || (state == uart_pkg::SEQ_SEND_LO);

  // high byte goes first.
  assign tx_byte = (state == uart_pkg::SEQ_SEND_HI) ? cmd_hold[15:8] : cmd_hold[7:0];

endmodule

/* source/tx_framer.sv */
`timescale 1ns/1ps

module tx_framer #(
  parameter int BIT_CYCLES = 16
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [uart_pkg::DATA_BITS-1:0] tx_byte,
  input  logic                           tx_start,
  output logic                           tx,
  output logic                           tx_done
);

  localparam logic [3:0] LAST_BIT = 4'(uart_pkg::FRAME_BITS - 1);

  logic [uart_pkg::FRAME_BITS-1:0] shreg; // bit 0 is on the line.
  logic [3:0]                      bit_cnt;
  logic                            active;
  logic                            bit_tick;

  baud_timer #(
    .BIT_CYCLES (BIT_CYCLES)
  ) u_baud_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (active),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active  <= 1'b0;
      bit_cnt <= '0;
    end else if (tx_start) begin
      active  <= 1'b1;
      bit_cnt <= '0;
    end else if (bit_tick) begin
      if (bit_cnt == LAST_BIT) begin
        active  <= 1'b0; // stop bit has ended.
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  // shifter fills with ones, so the line idles high after the stop bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shreg <= '1;
    end else if (tx_start) begin
      shreg <= {1'b1, uart_pkg::odd_parity(tx_byte), tx_byte, 1'b0};
    end else if (bit_tick) begin
      shreg <= {1'b1, shreg[uart_pkg::FRAME_BITS-1:1]};
    end
  end

  assign tx      = shreg[0];
  assign tx_done = bit_tick && (bit_cnt == LAST_BIT); // last cycle of the stop bit.

endmodule

/* source/rx_deframer.sv */
`timescale 1ns/1ps

module rx_deframer #(
  parameter int BIT_CYCLES   = 16,
  parameter int CHECK_PARITY = 1
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic       read_rdy,
  output logic [8:0] read_data
);

  uart_pkg::rx_state_e state;

  logic                           rx_meta;
  logic                           rx_sync;
  logic                           rx_prev;
  logic                           fall;
  logic                           mid_tick;
  logic [2:0]                     bit_cnt;
  logic [uart_pkg::DATA_BITS-1:0] data;
  logic                           par_err;

  // two-flop synchronizer, idle level is high.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;

  baud_timer #(
    .BIT_CYCLES (BIT_CYCLES)
  ) u_baud_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (state != uart_pkg::RX_IDLE),
    .bit_tick (),
    .mid_tick (mid_tick)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= uart_pkg::RX_IDLE;
      bit_cnt   <= '0;
      par_err   <= 1'b0;
      read_rdy  <= 1'b0;
      read_data <= '0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          if (fall) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (mid_tick) begin
            bit_cnt <= '0;
            // a glitch that is gone by mid-bit is no start bit.
            state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (mid_tick) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::RX_PARITY;
            end
          end
        end
        uart_pkg::RX_PARITY: begin
          if (mid_tick) begin
            par_err <= (CHECK_PARITY != 0) && (rx_sync != uart_pkg::odd_parity(data));
            state   <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (mid_tick) begin
            read_data <= {par_err || !rx_sync, data}; // low stop bit is a framing error.
            read_rdy  <= 1'b1;
            state     <= uart_pkg::RX_IDLE;
          end
        end
        default: begin
          state <= uart_pkg::RX_IDLE;
        end
      endcase
    end
  end

  // data arrives lsb first.
  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && mid_tick) begin
      data <= {rx_sync, data[uart_pkg::DATA_BITS-1:1]};
    end
  end

endmodule

/* source/uart_bridge.sv */
`timescale 1ns/1ps

module uart_bridge #(
  parameter int CLK_HZ       = 125000000,
  parameter int BAUD         = 7812500,
  parameter int CHECK_PARITY = 1
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  input  logic        rx,
  output logic        tx,
  output logic        cmd_rdy,
  output logic        read_rdy,
  output logic [8:0]  read_data
);

  localparam int BIT_CYCLES = CLK_HZ / BAUD; // clock cycles per bit.

  logic [7:0] tx_byte;
  logic       tx_start;
  logic       tx_done;

  cmd_sequencer u_cmd_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .tx_done  (tx_done),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start)
  );

  tx_framer #(
    .BIT_CYCLES (BIT_CYCLES)
  ) u_tx_framer (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  // receive side runs on its own, nothing throttles it.
  rx_deframer #(
    .BIT_CYCLES   (BIT_CYCLES),
    .CHECK_PARITY (CHECK_PARITY)
  ) u_rx_deframer (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

/* testbench/tb_uart_tasks.svh */
// parity bit that gives an odd number of ones over data and parity.
function automatic logic odd_bit(input logic [7:0] data);
  int ones;
  int i;
  ones = 0;
  for (i = 0; i < 8; i++) begin
    if (data[i]) begin
      ones = ones + 1;
    end
  end
  return (ones % 2) == 0; // an even count needs one more.
endfunction

// line pattern of one frame, bit 0 goes out first.
function automatic logic [10:0] frame_for(input logic [7:0] data);
  return {1'b1, odd_bit(data), data, 1'b0};
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  s = s ^ (s << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

// drives one frame on rx, parity and stop can be corrupted.
task automatic drive_frame(input logic [7:0] data, input logic bad_par, input logic bad_stop);
  logic [10:0] bits;
  int          b;
  bits = {~bad_stop, odd_bit(data) ^ bad_par, data, 1'b0};
  for (b = 0; b < FRAME_LEN; b++) begin
    @(posedge clk);
    #1;
    rx_drv = bits[b];
    repeat (BIT_CYCLES - 1) @(posedge clk);
  end
  @(posedge clk);
  #1;
  rx_drv = 1'b1;
  repeat (2 * BIT_CYCLES) @(posedge clk); // idle gap between frames.
endtask

// samples tx at mid-bit from each falling edge.
task automatic watch_tx();
  logic [10:0] got;
  logic        prev;
  int          b;
  prev = 1'b1;
  forever begin
    @(negedge clk);
    if (rst_n && prev && !tx) begin
      repeat (BIT_CYCLES / 2) @(negedge clk);
      got[0] = tx;
      for (b = 1; b < FRAME_LEN; b++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        got[b] = tx;
      end
      if (exp_tx_q.size() == 0) begin
        $display("a frame went out on tx while no command was pending");
        abort_run();
      end else begin
        check_frame(got, exp_tx_q.pop_front());
      end
    end
    prev = tx;
  end
endtask

task automatic check_read(input logic [8:0] got, input logic [8:0] exp);
  if (got !== exp) begin
    $display("mismatch read_data: got 0x%h expected 0x%h", got, exp);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    abort_run();
  end
endtask

task automatic check_frame(input logic [10:0] got, input logic [10:0] exp);
  if (got !== exp) begin
    $display("mismatch tx frame: got 0x%h expected 0x%h", got, exp);
    abort_run();
  end
endtask

/* testbench/tb_uart_bridge.sv */
`timescale 1ns/1ps

module tb_uart_bridge;

  localparam int CLK_HZ      = 125000000;
  localparam int BAUD        = 7812500;
  localparam int BIT_CYCLES  = CLK_HZ / BAUD;
  localparam int FRAME_LEN   = 11;
  localparam int BUSY_CYCLES = 2 * FRAME_LEN * BIT_CYCLES + 2; // cmd_rdy low time.
  localparam int N_FIXED     = 12;
  localparam int N_RAND      = 8;
  localparam int N_ROWS      = N_FIXED + N_RAND;
  localparam int TIMEOUT     = N_ROWS * (2 * FRAME_LEN * BIT_CYCLES + 200);

  localparam logic [1:0] MODE_LOOP   = 2'd0;
  localparam logic [1:0] MODE_INJECT = 2'd1;
  localparam logic [1:0] MODE_POKE   = 2'd2;
  localparam logic [1:0] MODE_HOLD   = 2'd3; // cmd_vld stays high into the next row.

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        rx_drv;
  logic        loop_en;
  logic        tx;
  logic        cmd_rdy;
  logic        read_rdy;
  logic [8:0]  read_data;
  int          cycles;

  logic [19:0] rows [N_ROWS]; // mode, bad parity, bad stop, command.
  logic [10:0] exp_tx_q [$];
  logic [8:0]  exp_rd_q [$];

  assign rx = loop_en ? tx : rx_drv;

  uart_bridge #(
    .CLK_HZ       (CLK_HZ),
    .BAUD         (BAUD),
    .CHECK_PARITY (1)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .tx        (tx),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "stopped at first error");
  endtask

  `include "tb_uart_tasks.svh"

  task automatic send_cmd(input logic [15:0] cmd, input logic poke, input logic hold,
                          input logic [15:0] next_cmd);
    int i;
    if (!cmd_vld) begin
      @(posedge clk);
      #1;
      cmd_in  = cmd;
      cmd_vld = 1'b1;
      @(negedge clk);
    end
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    @(posedge clk); // accepted at this edge.
    exp_tx_q.push_back(frame_for(cmd[15:8]));
    exp_tx_q.push_back(frame_for(cmd[7:0]));
    exp_rd_q.push_back({1'b0, cmd[15:8]});
    exp_rd_q.push_back({1'b0, cmd[7:0]});
    #1;
    if (hold) begin
      cmd_in = next_cmd;
    end else begin
      cmd_vld = 1'b0;
    end
    for (i = 0; i < BUSY_CYCLES; i++) begin
      @(negedge clk);
      check_bit("cmd_rdy", cmd_rdy, 1'b0);
      @(posedge clk);
      #1;
      if (poke) begin
        cmd_in  = ~cmd;
        cmd_vld = (i >= 1) && (i < BUSY_CYCLES - 2);
      end
    end
    @(negedge clk);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
  endtask

  task automatic wait_drained();
    while (exp_tx_q.size() != 0 || exp_rd_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
      abort_run();
    end
  end

  always @(negedge clk) begin
    if (rst_n && read_rdy) begin
      if (exp_rd_q.size() == 0) begin
        $display("read_rdy pulsed while no byte was expected");
        abort_run();
      end else begin
        check_read(read_data, exp_rd_q.pop_front());
      end
    end
  end

  initial watch_tx();

  initial begin
    logic [31:0] seed;
    logic [1:0]  mode;
    logic [15:0] cmd;
    logic [15:0] next_cmd;
    int          r;
    cycles  = 0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx_drv  = 1'b1;
    loop_en = 1'b1;
    rows[0]  = {MODE_LOOP, 2'b00, 16'h0000};
    rows[1]  = {MODE_LOOP, 2'b00, 16'hffff};
    rows[2]  = {MODE_LOOP, 2'b00, 16'ha55a};
    rows[3]  = {MODE_POKE, 2'b00, 16'h1234};
    rows[4]  = {MODE_LOOP, 2'b00, 16'h8001};
    rows[5]  = {MODE_INJECT, 2'b00, 16'h00c3};
    rows[6]  = {MODE_INJECT, 2'b10, 16'h00c3}; // bad parity.
    rows[7]  = {MODE_INJECT, 2'b01, 16'h007e}; // low stop bit.
    rows[8]  = {MODE_INJECT, 2'b11, 16'h0000};
    rows[9]  = {MODE_HOLD, 2'b00, 16'hbeef};
    rows[10] = {MODE_HOLD, 2'b00, 16'hcafe};
    rows[11] = {MODE_HOLD, 2'b00, 16'h0f0f};
    seed = 32'd44170;
    for (r = N_FIXED; r < N_ROWS; r++) begin
      seed    = xorshift32(seed);
      rows[r] = {MODE_LOOP, 2'b00, seed[15:0]};
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    check_bit("read_rdy", read_rdy, 1'b0);
    check_read(read_data, 9'h000);
    for (r = 0; r < N_ROWS; r++) begin
      mode     = rows[r][19:18];
      cmd      = rows[r][15:0];
      next_cmd = (r + 1 < N_ROWS) ? rows[r + 1][15:0] : 16'h0000;
      if (mode == MODE_INJECT) begin
        @(posedge clk);
        #1;
        loop_en = 1'b0;
        exp_rd_q.push_back({rows[r][17] | rows[r][16], cmd[7:0]});
        drive_frame(cmd[7:0], rows[r][17], rows[r][16]);
      end else begin
        if (!loop_en) begin
          @(posedge clk);
          #1;
          loop_en = 1'b1;
        end
        send_cmd(cmd, mode == MODE_POKE, mode == MODE_HOLD, next_cmd);
      end
      wait_drained();
    end
    // a whole stray frame fits in this window.
    repeat ((FRAME_LEN + 4) * BIT_CYCLES) @(negedge clk);
    check_bit("tx", tx, 1'b1);
    check_bit("cmd_rdy", cmd_rdy, 1'b1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* list.f */
+incdir+testbench
source/uart_pkg.sv
source/baud_timer.sv
source/cmd_sequencer.sv
source/tx_framer.sv
source/rx_deframer.sv
source/uart_bridge.sv
testbench/tb_uart_bridge.sv
